/* source/game_gfx_pkg.sv */
`default_nettype none

package game_gfx_pkg;

    typedef logic [9:0] coord_t;
    typedef logic signed [2:0] vel_t;

    // one bit each for red, green and blue, red in the top bit.
    typedef logic [2:0] rgb_t;

    localparam int sprite_size = 16;

    localparam rgb_t color_bg      = 3'b000;
    localparam rgb_t color_target  = 3'b110;
    localparam rgb_t color_torpedo = 3'b011;
    localparam rgb_t color_win     = 3'b010;
    localparam rgb_t color_lose    = 3'b100;

    typedef struct packed {
        coord_t left;
        coord_t right;
        coord_t top;
        coord_t bottom;
    } sprite_box_t;

    typedef struct packed {
        logic hit;
        rgb_t rgb;
    } sprite_pix_t;

endpackage

`default_nettype wire

/* source/game_ctrl_pkg.sv */
`default_nettype none

package game_ctrl_pkg;

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_play,
        st_end
    } game_state_t;

    // write_xy and write_vel are one-cycle strobes, enable_update is a level.
    typedef struct packed {
        logic write_xy;
        logic write_vel;
        logic enable_update;
    } sprite_ctrl_t;

    typedef struct packed {
        game_gfx_pkg::coord_t x;
        game_gfx_pkg::coord_t y;
        game_gfx_pkg::vel_t   dx;
        game_gfx_pkg::vel_t   dy;
    } sprite_init_t;

    typedef struct packed {
        game_state_t state;
        logic        won;
        logic        timer_running;
    } game_status_t;

endpackage

`default_nettype wire

/* source/game_random.sv */
`timescale 1ns/1ps
`default_nettype none

module game_random
(
    input  logic        clk,
    input  logic        rst_n,
    output logic [15:0] random
);

    logic feedback;

    // taps for x^16 + x^14 + x^13 + x^11 + 1, a maximal length sequence.
    assign feedback = random[15] ^ random[13] ^ random[12] ^ random[10];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            random <= '1;
        else
            random <= {random[14:0], feedback};
    end

endmodule

`default_nettype wire

/* source/game_spawn.sv */
`timescale 1ns/1ps
`default_nettype none

module game_spawn
#(
    parameter int screen_width  = 640,
    parameter int screen_height = 480
)
(
    input  logic [15:0]                 random,
    input  logic [1:0]                  left_right_keys,
    output game_ctrl_pkg::sprite_init_t target_init,
    output game_ctrl_pkg::sprite_init_t torpedo_init
);

    import game_gfx_pkg::*;
    import game_ctrl_pkg::*;

    // the target either crosses the top row from the left or sits near the middle.
    always_comb
    begin
        target_init.y  = '0;
        target_init.dy = '0;
        if (random[7])
        begin
            target_init.x  = '0;
            target_init.dx = vel_t'(1);
        end
        else
        begin
            target_init.x  = coord_t'(screen_width / 2) + coord_t'(random[2:0]);
            target_init.dx = '0;
        end
    end

    always_comb
    begin
        torpedo_init.x = coord_t'(screen_width / 2) + coord_t'(random[15:10]);
        torpedo_init.y = coord_t'(screen_height - sprite_size);
        // bit 0 is the right key and bit 1 the left key.
        case (left_right_keys)
            2'b01:
            begin
                torpedo_init.dx = vel_t'(1);
                torpedo_init.dy = vel_t'(-2);
            end
            2'b10:
            begin
                torpedo_init.dx = vel_t'(-1);
                torpedo_init.dy = vel_t'(-2);
            end
            2'b11:
            begin
                torpedo_init.dx = '0;
                torpedo_init.dy = vel_t'(-2);
            end
            default:
            begin
                torpedo_init.dx = '0;
                torpedo_init.dy = vel_t'(-1);
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/game_sprite.sv */
`timescale 1ns/1ps
`default_nettype none

module game_sprite
#(
    parameter int                  screen_width  = 640,
    parameter int                  screen_height = 480,
    parameter int                  strobe_width  = 20,
    parameter game_gfx_pkg::rgb_t sprite_color  = game_gfx_pkg::color_target
)
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  game_gfx_pkg::coord_t        x,
    input  game_gfx_pkg::coord_t        y,
    input  game_ctrl_pkg::sprite_init_t init,
    input  game_ctrl_pkg::sprite_ctrl_t ctrl,
    output game_gfx_pkg::sprite_box_t   box,
    output logic                        within_screen,
    output game_gfx_pkg::sprite_pix_t   pix
);

    import game_gfx_pkg::*;

    localparam int ext_width = $bits(coord_t) - $bits(vel_t);

    logic [strobe_width - 1:0] strobe_cnt;
    logic                      step;
    coord_t                    pos_x;
    coord_t                    pos_y;
    vel_t                      vel_x;
    vel_t                      vel_y;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            strobe_cnt <= '0;
        else
            strobe_cnt <= strobe_cnt + 1'b1;
    end

    assign step = &strobe_cnt;

    // positions wrap modulo the coordinate range, so moving up past row 0 lands at large y.
    always_ff @(posedge clk)
    begin
        if (ctrl.write_xy)
        begin
            pos_x <= init.x;
            pos_y <= init.y;
        end
        else if (ctrl.enable_update && step)
        begin
            pos_x <= pos_x + {{ext_width{vel_x[2]}}, vel_x};
            pos_y <= pos_y + {{ext_width{vel_y[2]}}, vel_y};
        end

        if (ctrl.write_vel)
        begin
            vel_x <= init.dx;
            vel_y <= init.dy;
        end
    end

    assign box.left   = pos_x;
    assign box.right  = pos_x + coord_t'(sprite_size - 1);
    assign box.top    = pos_y;
    assign box.bottom = pos_y + coord_t'(sprite_size - 1);

    assign within_screen = (int'(box.left) < screen_width) && (int'(box.top) < screen_height);

    assign pix.hit = (x >= box.left) && (x <= box.right) && (y >= box.top) && (y <= box.bottom);
    assign pix.rgb = sprite_color;

endmodule

`default_nettype wire

/* source/game_overlap.sv */
`timescale 1ns/1ps
`default_nettype none

module game_overlap
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  game_gfx_pkg::sprite_box_t box_a,
    input  game_gfx_pkg::sprite_box_t box_b,
    output logic                      overlap
);

    logic overlap_x;
    logic overlap_y;

    assign overlap_x = (box_a.left <= box_b.right) && (box_b.left <= box_a.right);
    assign overlap_y = (box_a.top <= box_b.bottom) && (box_b.top <= box_a.bottom);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            overlap <= 1'b0;
        else
            overlap <= overlap_x && overlap_y;
    end

endmodule

`default_nettype wire

/* source/game_master_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module game_master_fsm
#(
    parameter int end_delay = 2 ** 24
)
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        launch_key,
    input  logic                        target_within_screen,
    input  logic                        torpedo_within_screen,
    input  logic                        collision,
    output game_ctrl_pkg::sprite_ctrl_t target_ctrl,
    output game_ctrl_pkg::sprite_ctrl_t torpedo_ctrl,
    output game_ctrl_pkg::game_status_t status
);

    import game_ctrl_pkg::*;

    localparam int timer_width = $clog2(end_delay + 1);

    game_state_t              state;
    logic                     won;
    logic                     play_q;
    logic                     hit;
    logic [timer_width - 1:0] timer;

    // the overlap result lags the boxes by a cycle, so in the first play cycle
    // it still describes the positions of the previous game.
    assign hit = collision && play_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state  <= st_idle;
            won    <= 1'b0;
            play_q <= 1'b0;
            timer  <= '0;
        end
        else
        begin
            play_q <= (state == st_play);
            case (state)
                st_idle:
                    if (launch_key)
                        state <= st_start;
                st_start:
                begin
                    won   <= 1'b0;
                    state <= st_play;
                end
                st_play:
                    if (hit || !target_within_screen || !torpedo_within_screen)
                    begin
                        won   <= hit;
                        timer <= timer_width'(end_delay - 1);
                        state <= st_end;
                    end
                default:
                    if (timer == '0)
                        state <= st_idle;
                    else
                        timer <= timer - 1'b1;
            endcase
        end
    end

    always_comb
    begin
        target_ctrl  = '0;
        torpedo_ctrl = '0;
        case (state)
            st_start:
            begin
                target_ctrl.write_xy   = 1'b1;
                target_ctrl.write_vel  = 1'b1;
                torpedo_ctrl.write_xy  = 1'b1;
                torpedo_ctrl.write_vel = 1'b1;
            end
            st_play:
            begin
                target_ctrl.enable_update  = 1'b1;
                torpedo_ctrl.enable_update = 1'b1;
                // reloading the torpedo velocity lets the keys steer it live.
                torpedo_ctrl.write_vel     = 1'b1;
            end
        endcase
    end

    assign status.state         = state;
    assign status.won           = won;
    assign status.timer_running = (state == st_end);

endmodule

`default_nettype wire

/* source/game_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module game_mixer
#(
    parameter int screen_width  = 640,
    parameter int screen_height = 480
)
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        display_on,
    input  game_gfx_pkg::coord_t        x,
    input  game_gfx_pkg::coord_t        y,
    input  game_gfx_pkg::sprite_pix_t   target_pix,
    input  game_gfx_pkg::sprite_pix_t   torpedo_pix,
    input  game_ctrl_pkg::game_status_t status,
    output game_gfx_pkg::rgb_t          rgb
);

    import game_gfx_pkg::*;
    import game_ctrl_pkg::*;

    logic on_screen;
    logic in_play;

    assign on_screen = (int'(x) < screen_width) && (int'(y) < screen_height);
    assign in_play   = (status.state == st_play);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            rgb <= '0;
        else if (!display_on || !on_screen)
            rgb <= '0;
        else if (status.state == st_end)
            rgb <= status.won ? color_win : color_lose;
        else if (in_play && torpedo_pix.hit)
            rgb <= torpedo_pix.rgb;
        else if (in_play && target_pix.hit)
            rgb <= target_pix.rgb;
        else
            rgb <= color_bg;
    end

endmodule

`default_nettype wire

/* source/game_top.sv */
`timescale 1ns/1ps
`default_nettype none

module game_top
#(
    parameter int screen_width  = 640,
    parameter int screen_height = 480,
    parameter int strobe_width  = 20,
    parameter int end_delay     = 2 ** 24
)
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        launch_key,
    input  logic [1:0]                  left_right_keys,
    input  logic                        display_on,
    input  game_gfx_pkg::coord_t        x,
    input  game_gfx_pkg::coord_t        y,
    output game_gfx_pkg::rgb_t          rgb,
    output game_ctrl_pkg::game_status_t status
);

    import game_gfx_pkg::*;
    import game_ctrl_pkg::*;

    logic [15:0]  random;
    sprite_init_t target_init;
    sprite_init_t torpedo_init;
    sprite_ctrl_t target_ctrl;
    sprite_ctrl_t torpedo_ctrl;
    sprite_box_t  target_box;
    sprite_box_t  torpedo_box;
    sprite_pix_t  target_pix;
    sprite_pix_t  torpedo_pix;
    logic         target_within_screen;
    logic         torpedo_within_screen;
    logic         collision;

    game_random i_random
    (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .random ( random )
    );

    game_spawn #(.screen_width(screen_width), .screen_height(screen_height)) i_spawn
    (
        .random          ( random          ),
        .left_right_keys ( left_right_keys ),
        .target_init     ( target_init     ),
        .torpedo_init    ( torpedo_init    )
    );

    game_sprite
    #(
        .screen_width  ( screen_width  ),
        .screen_height ( screen_height ),
        .strobe_width  ( strobe_width  ),
        .sprite_color  ( color_target  )
    )
    i_target
    (
        .clk           ( clk                  ),
        .rst_n         ( rst_n                ),
        .x             ( x                    ),
        .y             ( y                    ),
        .init          ( target_init          ),
        .ctrl          ( target_ctrl          ),
        .box           ( target_box           ),
        .within_screen ( target_within_screen ),
        .pix           ( target_pix           )
    );

    game_sprite
    #(
        .screen_width  ( screen_width  ),
        .screen_height ( screen_height ),
        .strobe_width  ( strobe_width  ),
        .sprite_color  ( color_torpedo )
    )
    i_torpedo
    (
        .clk           ( clk                   ),
        .rst_n         ( rst_n                 ),
        .x             ( x                     ),
        .y             ( y                     ),
        .init          ( torpedo_init          ),
        .ctrl          ( torpedo_ctrl          ),
        .box           ( torpedo_box           ),
        .within_screen ( torpedo_within_screen ),
        .pix           ( torpedo_pix           )
    );

    game_overlap i_overlap
    (
        .clk     ( clk         ),
        .rst_n   ( rst_n       ),
        .box_a   ( target_box  ),
        .box_b   ( torpedo_box ),
        .overlap ( collision   )
    );

    game_master_fsm #(.end_delay(end_delay)) i_master_fsm
    (
        .clk                   ( clk                   ),
        .rst_n                 ( rst_n                 ),
        .launch_key            ( launch_key            ),
        .target_within_screen  ( target_within_screen  ),
        .torpedo_within_screen ( torpedo_within_screen ),
        .collision             ( collision             ),
        .target_ctrl           ( target_ctrl           ),
        .torpedo_ctrl          ( torpedo_ctrl          ),
        .status                ( status                )
    );

    game_mixer #(.screen_width(screen_width), .screen_height(screen_height)) i_mixer
    (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .display_on  ( display_on  ),
        .x           ( x           ),
        .y           ( y           ),
        .target_pix  ( target_pix  ),
        .torpedo_pix ( torpedo_pix ),
        .status      ( status      ),
        .rgb         ( rgb         )
    );

endmodule

`default_nettype wire

/* tests/game_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module game_assert
#(
    parameter int end_delay = 2 ** 24
)
(
    input logic                        clk,
    input logic                        rst_n,
    input game_ctrl_pkg::sprite_ctrl_t target_ctrl,
    input game_ctrl_pkg::sprite_ctrl_t torpedo_ctrl,
    input game_ctrl_pkg::game_status_t status
);

    import game_ctrl_pkg::*;

    int end_cycles;

    always_ff @(posedge clk)
    begin
        if (!rst_n || !status.timer_running)
            end_cycles <= 0;
        else
            end_cycles <= end_cycles + 1;
    end

    strobes_low_after_reset: assert property (@(posedge clk)
        !rst_n |=> (target_ctrl == '0) && (torpedo_ctrl == '0))
        else $error("sprite strobes active in the cycle after reset");

    start_lasts_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (status.state == st_start) |=> (status.state == st_play))
        else $error("start state did not move to play after one cycle");

    // the result fill runs for end_delay cycles and then hands back to idle.
    end_fill_length: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(status.timer_running) |-> (end_cycles == end_delay) && (status.state == st_idle))
        else $error("result fill did not last end_delay cycles before idle");

    write_xy_only_in_start: assert property (@(posedge clk) disable iff (!rst_n)
        (target_ctrl.write_xy || torpedo_ctrl.write_xy) |-> (status.state == st_start))
        else $error("position load outside the start state");

endmodule

bind game_master_fsm game_assert #(.end_delay(end_delay)) i_game_assert
(
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .target_ctrl  ( target_ctrl  ),
    .torpedo_ctrl ( torpedo_ctrl ),
    .status       ( status       )
);

`default_nettype wire

/* tests/game_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module game_tb;

    import game_gfx_pkg::*;
    import game_ctrl_pkg::*;

    localparam int screen_width  = 256;
    localparam int screen_height = 128;
    localparam int strobe_width  = 10;
    localparam int end_delay     = 2000;

    localparam rgb_t   black       = 3'b000;
    localparam coord_t torpedo_row = coord_t'(screen_height - sprite_size);

    localparam logic [1:0] out_idle  = 2'd0;
    localparam logic [1:0] out_lose  = 2'd1;
    localparam logic [1:0] out_model = 2'd2;

    typedef struct packed {
        logic [1:0] keys;
        logic       launch;
        logic [1:0] outcome;
    } scenario_t;

    localparam int num_scenarios = 5;
    localparam scenario_t scenarios [num_scenarios] = '{
        '{2'b00, 1'b0, out_idle},
        '{2'b00, 1'b1, out_model},
        '{2'b01, 1'b1, out_lose},
        '{2'b10, 1'b1, out_model},
        '{2'b00, 1'b1, out_model}
    };

    // the longest game is the torpedo climbing the whole screen one pixel per step.
    localparam int scenario_cycles = (screen_height + sprite_size) * (2 ** strobe_width)
                                     + end_delay + 16 * screen_width;
    localparam int timeout_cycles  = num_scenarios * scenario_cycles * 4;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         launch_key;
    logic [1:0]   left_right_keys;
    logic         display_on;
    coord_t       x;
    coord_t       y;
    rgb_t         rgb;
    game_status_t status;

    int unsigned lcg_state   = 46544;
    int          cycle_count = 0;
    int          errors      = 0;
    int          checks      = 0;

    game_top
    #(
        .screen_width  ( screen_width  ),
        .screen_height ( screen_height ),
        .strobe_width  ( strobe_width  ),
        .end_delay     ( end_delay     )
    )
    i_game_top
    (
        .clk             ( clk             ),
        .rst_n           ( rst_n           ),
        .launch_key      ( launch_key      ),
        .left_right_keys ( left_right_keys ),
        .display_on      ( display_on      ),
        .x               ( x               ),
        .y               ( y               ),
        .rgb             ( rgb             ),
        .status          ( status          )
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    initial
    begin
        wait (cycle_count >= timeout_cycles);
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // climbing two rows per step, the torpedo shares rows with the target only in the
    // last steps before it wraps past row 0. The scanned start may already be one step
    // old, so the outcome is only predicted when both possible starts agree.
    function automatic int predict_left_won(int target_x, int torpedo_x);
        int   first_step;
        int   last_step;
        int   col;
        int   votes;
        logic meets;
        first_step = (int'(torpedo_row) - sprite_size + 2) / 2;
        last_step  = int'(torpedo_row) / 2;
        votes      = 0;
        for (int start = torpedo_x; start <= torpedo_x + 1; start++)
        begin
            meets = 1'b0;
            for (int n = first_step; n <= last_step; n++)
            begin
                col = start - n;
                if (col <= target_x + sprite_size - 1 && target_x <= col + sprite_size - 1)
                    meets = 1'b1;
            end
            if (meets)
                votes++;
        end
        if (votes == 2)
            return 1;
        if (votes == 0)
            return 0;
        return -1;
    endfunction

    // a target entering from the left, or a torpedo steered right, never meets the other.
    function automatic int predict_won(logic [1:0] keys, int target_x, int torpedo_x);
        if (keys == 2'b01 || target_x <= 1)
            return 0;
        if (keys == 2'b00)
            return (torpedo_x <= target_x + sprite_size - 1) ? 1 : 0;
        if (keys == 2'b10)
            return predict_left_won(target_x, torpedo_x);
        return -1;
    endfunction

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, expected);
        end
    endtask

    task automatic check_state(input game_state_t got, input game_state_t expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("CHECK FAILED at %0t: status.state got %s expected %s",
                     $time, got.name(), expected.name());
        end
    endtask

    task automatic check_won(input logic got, input logic expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("CHECK FAILED at %0t: status.won got %b expected %b", $time, got, expected);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("FAILED at %0t: %s", $time, what);
    endtask

    task automatic probe_random(input rgb_t fill, input int count);
        coord_t px;
        coord_t py;
        logic   on;
        for (int i = 0; i < count; i++)
        begin
            px = coord_t'(lcg_next() % (screen_width + 32));
            py = coord_t'(lcg_next() % screen_height);
            on = (lcg_next() & 1) == 1;
            @(negedge clk);
            x          = px;
            y          = py;
            display_on = on;
            @(negedge clk);
            check_rgb("rgb", rgb, (on && int'(px) < screen_width) ? fill : black);
        end
    endtask

    // the colour of pixel i is read one cycle after it is driven.
    task automatic scan_row(input coord_t row, input rgb_t colour, output int first_x);
        first_x = -1;
        for (int i = 0; i <= screen_width; i++)
        begin
            @(negedge clk);
            if (i > 0 && first_x < 0 && rgb == colour)
                first_x = i - 1;
            if (i < screen_width)
            begin
                x          = coord_t'(i);
                y          = row;
                display_on = 1'b1;
            end
        end
    endtask

    task automatic wait_state(input game_state_t target);
        while (status.state != target)
            @(negedge clk);
    endtask

    task automatic run_scenario(input int index, input scenario_t sc);
        int   target_x;
        int   torpedo_x;
        int   second_x;
        int   low_x;
        int   high_x;
        int   expected_won;
        int   errors_before;
        rgb_t fill;
        errors_before = errors;
        @(negedge clk);
        left_right_keys = sc.keys;
        if (!sc.launch)
        begin
            repeat (64) @(negedge clk);
            check_state(status.state, st_idle);
            probe_random(color_bg, 8);
        end
        else
        begin
            launch_key = 1'b1;
            @(negedge clk);
            launch_key = 1'b0;
            wait_state(st_play);
            scan_row('0, color_target, target_x);
            if (target_x < 0 || (target_x > 1 && (target_x < screen_width / 2
                                 || target_x > screen_width / 2 + 7)))
                report_failure($sformatf("target starts at x %0d, off its spawn range",
                                         target_x));
            // one step may already have moved a steered torpedo by a pixel.
            low_x  = screen_width / 2 - ((sc.keys == 2'b10) ? 1 : 0);
            high_x = screen_width / 2 + 63 + ((sc.keys == 2'b01) ? 1 : 0);
            scan_row(torpedo_row, color_torpedo, torpedo_x);
            if (torpedo_x < low_x || torpedo_x > high_x)
                report_failure($sformatf("torpedo starts at x %0d, off its spawn range",
                                         torpedo_x));
            repeat (2 ** strobe_width + 64) @(negedge clk);
            check_state(status.state, st_play);
            scan_row(torpedo_row, color_torpedo, second_x);
            case (sc.keys)
                2'b01:
                    if (second_x < torpedo_x)
                        report_failure("torpedo moved left with the right key held");
                2'b10:
                    if (second_x > torpedo_x)
                        report_failure("torpedo moved right with the left key held");
                default:
                    if (second_x != torpedo_x)
                        report_failure("torpedo moved sideways with no key held");
            endcase
            while (!status.timer_running)
                @(negedge clk);
            check_state(status.state, st_end);
            expected_won = (sc.outcome == out_lose) ? 0
                           : predict_won(sc.keys, target_x, torpedo_x);
            if (expected_won >= 0)
            begin
                check_won(status.won, expected_won == 1);
                fill = (expected_won == 1) ? color_win : color_lose;
            end
            else
                fill = status.won ? color_win : color_lose;
            probe_random(fill, 6);
            wait_state(st_idle);
            probe_random(color_bg, 4);
        end
        $display("scenario %0d, keys %b, launch %0d: %s", index, sc.keys, sc.launch,
                 (errors == errors_before) ? "passed" : "failed");
    endtask

    initial
    begin
        rst_n           = 1'b0;
        launch_key      = 1'b0;
        left_right_keys = 2'b00;
        display_on      = 1'b0;
        x               = '0;
        y               = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_state(status.state, st_idle);
        probe_random(color_bg, 12);
        $display("reset test: %s", (errors == 0) ? "passed" : "failed");
        for (int i = 0; i < num_scenarios; i++)
            run_scenario(i, scenarios[i]);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
source/game_gfx_pkg.sv
source/game_ctrl_pkg.sv
source/game_random.sv
source/game_spawn.sv
source/game_sprite.sv
source/game_overlap.sv
source/game_master_fsm.sv
source/game_mixer.sv
source/game_top.sv
tests/game_assert.sv
tests/game_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = game_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)
